/* common/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// datapath widths

`define DATA_W 32   // operands and result
`define OP_W 6      // opcode field of the control word
`define SHAMT_W 5   // shift amount field, upper bits of the control word
`define ACC_W 64    // HI:LO together

`endif

/* common/aluOpPkg.sv */
`default_nettype none

`include "alu_defs.svh"

package aluOpPkg;

  //////////////////////////////////////////////////////////////////////
  // operation codes, same 6-bit encodings as the original ALU
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [`OP_W-1:0] {
    opAdd   = 6'b000000,
    opAddu  = 6'b000001,
    opAnd   = 6'b000010,
    opSub   = 6'b000011,
    opMult  = 6'b000100,
    opMultu = 6'b000101,
    opMthi  = 6'b000110,
    opMtlo  = 6'b000111,
    opMfhi  = 6'b001000,
    opMflo  = 6'b001001,
    opOr    = 6'b001011,  // 001010 was jr
    opNor   = 6'b001100,
    opXor   = 6'b001101,
    opSll   = 6'b001110,
    opSlt   = 6'b001111,
    opSltu  = 6'b010000,
    opSra   = 6'b010001,
    opSrav  = 6'b010010,
    opSrl   = 6'b010011,
    opSrlv  = 6'b010100,
    opSllv  = 6'b010101,
    opRotrv = 6'b011000,  // gap left by movn/movz
    opRotr  = 6'b011001,
    opBeq   = 6'b011101,
    opMul   = 6'b011110,
    opMadd  = 6'b011111,
    opMsub  = 6'b100000,
    opBgez  = 6'b101000,
    opBltz  = 6'b101001,
    opBne   = 6'b101010,
    opBgtz  = 6'b101011,
    opBlez  = 6'b101100
  } opT;

  // control word as issued by the decoder, shamt sits on top
  typedef struct packed {
    logic [`SHAMT_W-1:0] shamt;
    opT                  op;
  } ctrlT;

endpackage

`default_nettype wire

/* common/accPkg.sv */
`default_nettype none

`include "alu_defs.svh"

package accPkg;

  // HI in the upper word, LO in the lower
  typedef struct packed {
    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;
  } halvesT;

  // madd/msub see one signed value, the moves see two words
  typedef union packed {
    logic signed [`ACC_W-1:0] full;
    halvesT                   halves;
  } accT;

endpackage

`default_nettype wire

/* logic/integerUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module integerUnit (
  input  aluOpPkg::opT         op,
  input  logic [`SHAMT_W-1:0]  shamt,
  input  logic [`DATA_W-1:0]   a,
  input  logic [`DATA_W-1:0]   b,
  output logic [`DATA_W-1:0]   intResult,
  output logic                 intClaim
);

  logic [`SHAMT_W-1:0] varAmt;     // variable shift amount from a
  logic                lessSigned;
  logic                lessUnsigned;

  // right rotate out of a right and a left shift
  function automatic logic [`DATA_W-1:0] rotRight(
    input logic [`DATA_W-1:0]  val,
    input logic [`SHAMT_W-1:0] amt
  );
    logic [`DATA_W-1:0] lowPart;
    logic [`DATA_W-1:0] highPart;
    lowPart  = val >> amt;
    highPart = val << (`SHAMT_W+1)'(`DATA_W - amt);  // amt 0 shifts all out
    return lowPart | highPart;
  endfunction

  assign varAmt       = a[`SHAMT_W-1:0];
  assign lessSigned   = $signed(a) < $signed(b);
  assign lessUnsigned = a < b;

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    intClaim  = 1'b1;
    intResult = '0;
    case (op)
      aluOpPkg::opAdd,
      aluOpPkg::opAddu:
        intResult = a + b;    // wraps, no overflow trap
      aluOpPkg::opSub:
        intResult = a - b;
      aluOpPkg::opAnd:
        intResult = a & b;
      aluOpPkg::opOr:
        intResult = a | b;
      aluOpPkg::opNor:
        intResult = ~(a | b);
      aluOpPkg::opXor:
        intResult = a ^ b;
      aluOpPkg::opSlt:
        intResult = {{(`DATA_W-1){1'b0}}, lessSigned};
      aluOpPkg::opSltu:
        intResult = {{(`DATA_W-1){1'b0}}, lessUnsigned};
      aluOpPkg::opSll:
        intResult = b << shamt;
      aluOpPkg::opSllv:
        intResult = b << varAmt;
      aluOpPkg::opSrl:
        intResult = b >> shamt;
      aluOpPkg::opSrlv:
        intResult = b >> varAmt;
      aluOpPkg::opSra:
        intResult = $signed(b) >>> shamt;   // sign fill
      aluOpPkg::opSrav:
        intResult = $signed(b) >>> varAmt;
      aluOpPkg::opRotr:
        intResult = rotRight(b, shamt);
      aluOpPkg::opRotrv:
        intResult = rotRight(b, varAmt);
      default:
        intClaim = 1'b0;      // not ours
    endcase
  end

endmodule

`default_nettype wire

/* logic/branchCompare.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module branchCompare (
  input  aluOpPkg::opT        op,
  input  logic [`DATA_W-1:0]  a,
  input  logic [`DATA_W-1:0]  b,
  output logic                takeBranch
);

  logic aEqB;
  logic aNeg;
  logic aZero;

  assign aEqB  = a == b;
  assign aNeg  = a[`DATA_W-1];      // sign bit
  assign aZero = a == '0;

  // branch conditions, everything else never branches
  always_comb
  begin
    case (op)
      aluOpPkg::opBeq:
        takeBranch = aEqB;
      aluOpPkg::opBne:
        takeBranch = !aEqB;
      aluOpPkg::opBgez:
        takeBranch = !aNeg;
      aluOpPkg::opBltz:
        takeBranch = aNeg;
      aluOpPkg::opBgtz:
        takeBranch = !aNeg && !aZero;   // strictly positive
      aluOpPkg::opBlez:
        takeBranch = aNeg || aZero;
      default:
        takeBranch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hiLo/hiLoUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module hiLoUnit (
  input  logic                Clk,
  input  logic                rstN,
  input  logic                opValid,
  input  aluOpPkg::opT        op,
  input  logic [`DATA_W-1:0]  a,
  input  logic [`DATA_W-1:0]  b,
  output logic [`DATA_W-1:0]  hiLoResult,
  output logic                hiLoClaim
);

  accPkg::accT              acc;      // HI:LO register
  accPkg::accT              accNext;
  logic signed [`ACC_W-1:0] prodS;
  logic [`ACC_W-1:0]        prodU;

  //////////////////////////////////////////////////////////////////////
  // multiplier
  //////////////////////////////////////////////////////////////////////

  // both operands widened to 64 bits first, sign or zero fill
  assign prodS = $signed({{`DATA_W{a[`DATA_W-1]}}, a}) *
                 $signed({{`DATA_W{b[`DATA_W-1]}}, b});
  assign prodU = {{`DATA_W{1'b0}}, a} * {{`DATA_W{1'b0}}, b};

  //////////////////////////////////////////////////////////////////////
  // next HI:LO
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    accNext = acc;    // hold by default
    case (op)
      aluOpPkg::opMult:
        accNext.full = prodS;
      aluOpPkg::opMultu:
        accNext.full = prodU;
      aluOpPkg::opMadd:
        accNext.full = acc.full + prodS;
      aluOpPkg::opMsub:
        accNext.full = acc.full - prodS;
      aluOpPkg::opMthi:
        accNext.halves.hi = a;    // LO untouched
      aluOpPkg::opMtlo:
        accNext.halves.lo = a;
      default:
        accNext = acc;
    endcase
  end

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      acc.full <= '0;
    end
    else if (opValid)
    begin
      acc <= accNext;
    end
  end

  // read side, comb
  always_comb
  begin
    hiLoClaim  = 1'b1;
    hiLoResult = '0;
    case (op)
      aluOpPkg::opMfhi:
        hiLoResult = acc.halves.hi;
      aluOpPkg::opMflo:
        hiLoResult = acc.halves.lo;
      aluOpPkg::opMul:
        hiLoResult = prodS[`DATA_W-1:0];  // low word, HI:LO untouched
      aluOpPkg::opMult,
      aluOpPkg::opMultu,
      aluOpPkg::opMadd,
      aluOpPkg::opMsub,
      aluOpPkg::opMthi,
      aluOpPkg::opMtlo:
        hiLoResult = '0;    // write-only ops
      default:
        hiLoClaim = 1'b0;
    endcase
  end

  // only an issued write op moves HI:LO, so no issue means no change
  accHoldsWhenIdle: assert property (
    @(posedge Clk) disable iff (!rstN)
    !(opValid && (op inside {aluOpPkg::opMult, aluOpPkg::opMultu, aluOpPkg::opMadd,
                             aluOpPkg::opMsub, aluOpPkg::opMthi, aluOpPkg::opMtlo}))
      |=> $stable(acc.full)
  );

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module aluUnit (
  input  logic                Clk,
  input  logic                rstN,
  input  logic                opValid,
  input  aluOpPkg::ctrlT      aluControl,
  input  logic [`DATA_W-1:0]  a,
  input  logic [`DATA_W-1:0]  b,
  output logic [`DATA_W-1:0]  aluResult,
  output logic                takeBranch
);

  logic [`DATA_W-1:0] intResult;
  logic               intClaim;
  logic [`DATA_W-1:0] hiLoResult;
  logic               hiLoClaim;

  //////////////////////////////////////////////////////////////////////
  // units
  //////////////////////////////////////////////////////////////////////

  integerUnit intUnit0 (
    .op        (aluControl.op),
    .shamt     (aluControl.shamt),
    .a         (a),
    .b         (b),
    .intResult (intResult),
    .intClaim  (intClaim)
  );

  branchCompare brCmp0 (
    .op         (aluControl.op),
    .a          (a),
    .b          (b),
    .takeBranch (takeBranch)
  );

  hiLoUnit hiLo0 (
    .Clk        (Clk),
    .rstN       (rstN),
    .opValid    (opValid),
    .op         (aluControl.op),
    .a          (a),
    .b          (b),
    .hiLoResult (hiLoResult),
    .hiLoClaim  (hiLoClaim)
  );

  // claiming unit wins, unclaimed opcodes read zero
  always_comb
  begin
    if (intClaim)
      aluResult = intResult;
    else if (hiLoClaim)
      aluResult = hiLoResult;
    else
      aluResult = '0;
  end

  // opcode decode across units must be disjoint, branches claim nothing else
  claimsDisjoint: assert property (
    @(posedge Clk) disable iff (!rstN)
    !(intClaim && hiLoClaim) && !(takeBranch && (intClaim || hiLoClaim))
  );

endmodule

`default_nettype wire

/* bench/aluUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module aluUnitTb;

  localparam int RESET_LIMIT = 20;   // cycles allowed for reset release
  localparam int RAND_ROWS   = 40;

  // one table entry, expected values worked out when the row is added
  typedef struct {
    string               name;
    logic                valid;
    aluOpPkg::ctrlT      ctrl;
    logic [`DATA_W-1:0]  a;
    logic [`DATA_W-1:0]  b;
    logic [`DATA_W-1:0]  expResult;
    logic                expBranch;
  } rowT;

  logic                Clk;
  logic                rstN;
  logic                opValid;
  aluOpPkg::ctrlT      aluControl;
  logic [`DATA_W-1:0]  a;
  logic [`DATA_W-1:0]  b;
  logic [`DATA_W-1:0]  aluResult;
  logic                takeBranch;

  rowT                 rows[$];
  accPkg::accT         modelAcc;     // HI:LO as the table expects it
  aluOpPkg::opT        randomOps [0:19];
  integer              seed;

  aluUnit dut0 (
    .Clk        (Clk),
    .rstN       (rstN),
    .opValid    (opValid),
    .aluControl (aluControl),
    .a          (a),
    .b          (b),
    .aluResult  (aluResult),
    .takeBranch (takeBranch)
  );

  initial
  begin
    Clk = 1'b0;
    forever #4 Clk = ~Clk;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (3) @(posedge Clk);
    rstN <= 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [`DATA_W-1:0] expectResult(
    input aluOpPkg::opT        op,
    input logic [`SHAMT_W-1:0] shamt,
    input logic [`DATA_W-1:0]  opA,
    input logic [`DATA_W-1:0]  opB
  );
    logic [`DATA_W-1:0]   res;
    logic [2*`DATA_W-1:0] wide;
    logic [`SHAMT_W-1:0]  amt;
    longint               prod;
    res  = '0;
    prod = longint'($signed(opA)) * longint'($signed(opB));
    amt  = shamt;
    if (op inside {aluOpPkg::opSllv, aluOpPkg::opSrlv, aluOpPkg::opSrav, aluOpPkg::opRotrv})
      amt = opA[`SHAMT_W-1:0];    // variable forms
    case (op)
      aluOpPkg::opAdd, aluOpPkg::opAddu: res = opA + opB;
      aluOpPkg::opSub:                   res = opA - opB;
      aluOpPkg::opAnd:                   res = opA & opB;
      aluOpPkg::opOr:                    res = opA | opB;
      aluOpPkg::opNor:                   res = ~(opA | opB);
      aluOpPkg::opXor:                   res = opA ^ opB;
      aluOpPkg::opSlt:                   res[0] = (opA ^ 32'h8000_0000) < (opB ^ 32'h8000_0000);
      aluOpPkg::opSltu:                  res[0] = opA < opB;
      aluOpPkg::opSll, aluOpPkg::opSllv: res = opB << amt;
      aluOpPkg::opSrl, aluOpPkg::opSrlv: res = opB >> amt;
      aluOpPkg::opSra, aluOpPkg::opSrav:
      begin
        wide = {{`DATA_W{opB[`DATA_W-1]}}, opB} >> amt;
        res  = wide[`DATA_W-1:0];
      end
      aluOpPkg::opRotr, aluOpPkg::opRotrv:
      begin
        wide = {opB, opB} >> amt;   // bits fall back in from the top copy
        res  = wide[`DATA_W-1:0];
      end
      aluOpPkg::opMul:  res = 32'(prod);
      aluOpPkg::opMfhi: res = modelAcc.halves.hi;
      aluOpPkg::opMflo: res = modelAcc.halves.lo;
      default:          res = '0;
    endcase
    return res;
  endfunction

  function automatic logic expectBranch(
    input aluOpPkg::opT       op,
    input logic [`DATA_W-1:0] opA,
    input logic [`DATA_W-1:0] opB
  );
    int sa;
    sa = $signed(opA);
    case (op)
      aluOpPkg::opBeq:  return opA == opB;
      aluOpPkg::opBne:  return opA != opB;
      aluOpPkg::opBgez: return sa >= 0;
      aluOpPkg::opBltz: return sa < 0;
      aluOpPkg::opBgtz: return sa > 0;
      aluOpPkg::opBlez: return sa <= 0;
      default:          return 1'b0;
    endcase
  endfunction

  // HI:LO after an issued op
  function automatic void updateModel(
    input aluOpPkg::opT       op,
    input logic [`DATA_W-1:0] opA,
    input logic [`DATA_W-1:0] opB
  );
    longint               sProd;
    logic [2*`DATA_W-1:0] uProd;
    sProd = longint'($signed(opA)) * longint'($signed(opB));
    uProd = {32'b0, opA} * {32'b0, opB};
    case (op)
      aluOpPkg::opMult:  modelAcc.full = sProd;
      aluOpPkg::opMultu: modelAcc.full = uProd;
      aluOpPkg::opMadd:  modelAcc.full = modelAcc.full + sProd;
      aluOpPkg::opMsub:  modelAcc.full = modelAcc.full - sProd;
      aluOpPkg::opMthi:  modelAcc.halves.hi = opA;
      aluOpPkg::opMtlo:  modelAcc.halves.lo = opA;
      default:           ;
    endcase
  endfunction

  task automatic addRow(
    input string               name,
    input logic                valid,
    input aluOpPkg::opT        op,
    input logic [`SHAMT_W-1:0] shamt,
    input logic [`DATA_W-1:0]  opA,
    input logic [`DATA_W-1:0]  opB
  );
    rowT row;
    row.name       = name;
    row.valid      = valid;
    row.ctrl.shamt = shamt;
    row.ctrl.op    = op;
    row.a          = opA;
    row.b          = opB;
    row.expResult  = expectResult(op, shamt, opA, opB);   // reads HI:LO before the edge
    row.expBranch  = expectBranch(op, opA, opB);
    rows.push_back(row);
    if (valid)
      updateModel(op, opA, opB);
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic checkResult(input string name, input logic [`DATA_W-1:0] expected,
                             input logic [`DATA_W-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %s aluResult expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "aluResult mismatch");
    end
  endtask

  task automatic checkBranch(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("ERR %s takeBranch expected %b actual %b", name, expected, actual);
      $display("test failed");
      $fatal(1, "takeBranch mismatch");
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("timeout: %s", what);
    $display("test failed");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  task automatic buildTable();
    logic [`DATA_W-1:0] pick;
    logic [`DATA_W-1:0] ra;
    logic [`DATA_W-1:0] rb;
    // HI:LO right after reset
    addRow("resetHi", 1'b1, aluOpPkg::opMfhi, 5'd0, 32'h0, 32'h0);
    addRow("resetLo", 1'b1, aluOpPkg::opMflo, 5'd0, 32'h0, 32'h0);
    addRow("addWrap", 1'b1, aluOpPkg::opAdd, 5'd0, 32'h7fff_ffff, 32'h0000_0001);
    addRow("adduCarry", 1'b1, aluOpPkg::opAddu, 5'd0, 32'hffff_ffff, 32'h0000_0002);
    addRow("subBorrow", 1'b1, aluOpPkg::opSub, 5'd0, 32'h0, 32'h1);
    addRow("and", 1'b1, aluOpPkg::opAnd, 5'd0, 32'hf0f0_1234, 32'h0ff0_ffff);
    addRow("or", 1'b1, aluOpPkg::opOr, 5'd0, 32'hf0f0_1234, 32'h0ff0_0000);
    addRow("nor", 1'b1, aluOpPkg::opNor, 5'd0, 32'hf0f0_1234, 32'h0ff0_0000);
    addRow("xor", 1'b1, aluOpPkg::opXor, 5'd0, 32'hffff_0000, 32'h0ff0_0ff0);
    addRow("sltNeg", 1'b1, aluOpPkg::opSlt, 5'd0, 32'h8000_0000, 32'h0000_0001);
    addRow("sltuNeg", 1'b1, aluOpPkg::opSltu, 5'd0, 32'h8000_0000, 32'h0000_0001);
    addRow("sltPos", 1'b1, aluOpPkg::opSlt, 5'd0, 32'h0000_0001, 32'hffff_ffff);
    addRow("sltEq", 1'b1, aluOpPkg::opSlt, 5'd0, 32'h7fff_ffff, 32'h7fff_ffff);
    // shifts and rotates, fixed then variable
    addRow("sll0", 1'b1, aluOpPkg::opSll, 5'd0, 32'h0, 32'h8000_0001);
    addRow("sll31", 1'b1, aluOpPkg::opSll, 5'd31, 32'h0, 32'h8000_0003);
    addRow("srl31", 1'b1, aluOpPkg::opSrl, 5'd31, 32'h0, 32'h8000_0000);
    addRow("sra31", 1'b1, aluOpPkg::opSra, 5'd31, 32'h0, 32'h8000_0001);
    addRow("sraPos", 1'b1, aluOpPkg::opSra, 5'd4, 32'h0, 32'h7000_00f0);
    addRow("sllv", 1'b1, aluOpPkg::opSllv, 5'd0, 32'h0000_0024, 32'h1234_5678);
    addRow("srlv31", 1'b1, aluOpPkg::opSrlv, 5'd0, 32'hffff_ffff, 32'h8000_0000);
    addRow("srav", 1'b1, aluOpPkg::opSrav, 5'd0, 32'h0000_0021, 32'hf000_0000);
    addRow("rotr0", 1'b1, aluOpPkg::opRotr, 5'd0, 32'h0, 32'hdead_beef);
    addRow("rotr31", 1'b1, aluOpPkg::opRotr, 5'd31, 32'h0, 32'h8000_0001);
    addRow("rotrv", 1'b1, aluOpPkg::opRotrv, 5'd0, 32'h0000_0028, 32'h1234_5678);
    // branches
    addRow("beqTaken", 1'b1, aluOpPkg::opBeq, 5'd0, 32'h55aa_0001, 32'h55aa_0001);
    addRow("beqNot", 1'b1, aluOpPkg::opBeq, 5'd0, 32'h55aa_0001, 32'h55aa_0002);
    addRow("bneTaken", 1'b1, aluOpPkg::opBne, 5'd0, 32'h1, 32'h2);
    addRow("bneNot", 1'b1, aluOpPkg::opBne, 5'd0, 32'h7, 32'h7);
    addRow("bgezZero", 1'b1, aluOpPkg::opBgez, 5'd0, 32'h0, 32'h0);
    addRow("bgezNeg", 1'b1, aluOpPkg::opBgez, 5'd0, 32'hffff_ffff, 32'h0);
    addRow("bltzNeg", 1'b1, aluOpPkg::opBltz, 5'd0, 32'h8000_0000, 32'h0);
    addRow("bltzZero", 1'b1, aluOpPkg::opBltz, 5'd0, 32'h0, 32'h0);
    addRow("bgtzZero", 1'b1, aluOpPkg::opBgtz, 5'd0, 32'h0, 32'h0);
    addRow("bgtzPos", 1'b1, aluOpPkg::opBgtz, 5'd0, 32'h7fff_ffff, 32'h0);
    addRow("blezZero", 1'b1, aluOpPkg::opBlez, 5'd0, 32'h0, 32'h0);
    addRow("blezPos", 1'b1, aluOpPkg::opBlez, 5'd0, 32'h1, 32'h0);
    addRow("addEqual", 1'b1, aluOpPkg::opAdd, 5'd0, 32'h5, 32'h5);   // flag stays low
    // products into HI:LO
    addRow("mult", 1'b1, aluOpPkg::opMult, 5'd0, 32'hffff_fffd, 32'h8000_0007);
    addRow("multHi", 1'b1, aluOpPkg::opMfhi, 5'd0, 32'h0, 32'h0);
    addRow("multLo", 1'b1, aluOpPkg::opMflo, 5'd0, 32'h0, 32'h0);
    addRow("multu", 1'b1, aluOpPkg::opMultu, 5'd0, 32'hffff_fffd, 32'h8000_0007);
    addRow("multuHi", 1'b1, aluOpPkg::opMfhi, 5'd0, 32'h0, 32'h0);
    addRow("multuLo", 1'b1, aluOpPkg::opMflo, 5'd0, 32'h0, 32'h0);
    // accumulate onto moved-in values, madd borrows out of LO into HI
    addRow("mthi", 1'b1, aluOpPkg::opMthi, 5'd0, 32'h0000_0001, 32'h0);
    addRow("mtlo", 1'b1, aluOpPkg::opMtlo, 5'd0, 32'h0000_0005, 32'h0);
    addRow("madd", 1'b1, aluOpPkg::opMadd, 5'd0, 32'hffff_fffd, 32'h0000_0005);
    addRow("maddHi", 1'b1, aluOpPkg::opMfhi, 5'd0, 32'h0, 32'h0);
    addRow("maddLo", 1'b1, aluOpPkg::opMflo, 5'd0, 32'h0, 32'h0);
    addRow("msub", 1'b1, aluOpPkg::opMsub, 5'd0, 32'h1234_5678, 32'h9abc_def0);
    addRow("msubHi", 1'b1, aluOpPkg::opMfhi, 5'd0, 32'h0, 32'h0);
    addRow("msubLo", 1'b1, aluOpPkg::opMflo, 5'd0, 32'h0, 32'h0);
    // not issued, so no HI:LO change
    addRow("idleMthi", 1'b0, aluOpPkg::opMthi, 5'd0, 32'hffff_ffff, 32'h0);
    addRow("idleMadd", 1'b0, aluOpPkg::opMadd, 5'd0, 32'h7fff_ffff, 32'h7fff_ffff);
    addRow("idleHi", 1'b1, aluOpPkg::opMfhi, 5'd0, 32'h0, 32'h0);
    addRow("idleLo", 1'b1, aluOpPkg::opMflo, 5'd0, 32'h0, 32'h0);
    addRow("mulLow", 1'b1, aluOpPkg::opMul, 5'd0, 32'hffff_ffff, 32'hffff_ffff);
    for (int i = 0; i < RAND_ROWS; i++)
    begin
      pick = $random(seed);
      ra   = $random(seed);
      rb   = $random(seed);
      if (pick[7:5] == 3'd0)
        rb = ra;    // lets beq/bne see equal operands
      addRow($sformatf("rand%0d", i), pick[9] | pick[10], randomOps[pick[15:11] % 20],
             pick[4:0], ra, rb);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int waitCycles;
    opValid    = 1'b0;
    aluControl = '0;
    a          = '0;
    b          = '0;
    seed       = 32'haafe_862b;
    modelAcc   = '0;
    randomOps  = '{aluOpPkg::opAdd, aluOpPkg::opSub, aluOpPkg::opAnd, aluOpPkg::opXor,
                   aluOpPkg::opSlt, aluOpPkg::opSltu, aluOpPkg::opSrav, aluOpPkg::opRotrv,
                   aluOpPkg::opRotr, aluOpPkg::opSll, aluOpPkg::opBeq, aluOpPkg::opBne,
                   aluOpPkg::opBgtz, aluOpPkg::opBlez, aluOpPkg::opMul, aluOpPkg::opMult,
                   aluOpPkg::opMadd, aluOpPkg::opMsub, aluOpPkg::opMfhi, aluOpPkg::opMflo};
    buildTable();

    waitCycles = 0;
    while (rstN !== 1'b1 && waitCycles < RESET_LIMIT)
    begin
      @(posedge Clk);
      waitCycles++;
    end
    if (rstN !== 1'b1)
      reportTimeout("reset was never released");

    for (int i = 0; i < rows.size(); i++)
    begin
      @(posedge Clk);
      opValid    <= rows[i].valid;
      aluControl <= rows[i].ctrl;
      a          <= rows[i].a;
      b          <= rows[i].b;
      @(negedge Clk);   // comb outputs settled mid-cycle
      checkResult(rows[i].name, rows[i].expResult, aluResult);
      checkBranch(rows[i].name, rows[i].expBranch, takeBranch);
    end

    @(posedge Clk);
    opValid <= 1'b0;
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* aluUnit.f */
+incdir+common
common/aluOpPkg.sv
common/accPkg.sv
logic/integerUnit.sv
logic/branchCompare.sv
hiLo/hiLoUnit.sv
logic/aluUnit.sv
bench/aluUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Verilator build and run of the ALU testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f aluUnit.f --top-module aluUnitTb -o aluUnitSim

simOut=$(./obj_dir/aluUnitSim 2>&1) || true
echo "$simOut"

if echo "$simOut" | grep -q "^test passed$"; then
  exit 0
else
  exit 1
fi
